/* design/aluPkg.sv */
package aluPkg;

   // datapath sizes
   localparam int dataWidth    = 8;
   localparam int regCount     = 8;
   localparam int regAddrWidth = 3;
   localparam int flagWidth    = 4;

   // flag bit positions, same order as the original flag register
   localparam int flagV = 0; // overflow
   localparam int flagN = 1; // negative
   localparam int flagC = 2; // carry, means no borrow after subtract
   localparam int flagZ = 3; // zero

   typedef logic [dataWidth-1:0]    data_t;
   typedef logic [regAddrWidth-1:0] regAddr_t;
   typedef logic [flagWidth-1:0]    flags_t;

   typedef enum logic [3:0] {
      opPassA = 4'd0,
      opPassB = 4'd1,
      opNotA  = 4'd2,
      opNotB  = 4'd3,
      opAdd   = 4'd4,
      opAdc   = 4'd5,  // adds stored carry
      opSub   = 4'd6,
      opAnd   = 4'd7,
      opOr    = 4'd8,
      opNand  = 4'd9,
      opXor   = 4'd10,
      opLsl   = 4'd11,
      opLsr   = 4'd12,
      opAsr   = 4'd13,
      opRor   = 4'd14,
      opCmp   = 4'd15  // subtract without write-back
   } aluOp_e;

endpackage

/* design/cmdDecode.sv */
`timescale 1ns/1ps

module cmdDecode (
   input  logic              clk,
   input  logic              rst,
   input  logic              cmdValid,
   input  aluPkg::aluOp_e    cmdOp,
   input  aluPkg::regAddr_t  cmdDst,
   input  aluPkg::regAddr_t  cmdSrcA,
   input  aluPkg::regAddr_t  cmdSrcB,
   input  aluPkg::data_t     cmdImm,
   input  logic              cmdUseImm,
   input  logic              exeReady,
   output logic              cmdReady,
   output logic              decValid,
   output aluPkg::aluOp_e    decOp,
   output aluPkg::regAddr_t  decDst,
   output aluPkg::regAddr_t  decSrcA,
   output aluPkg::regAddr_t  decSrcB,
   output aluPkg::data_t     decImm,
   output logic              decUseImm,
   output logic              decRegWrite,
   output logic              decUpdCarry,
   output logic              decUpdOvf
);

   logic accept;

   assign cmdReady = !decValid || exeReady; // slot empty or draining
   assign accept   = cmdValid && cmdReady;

   always_ff @(posedge clk) begin
      if (rst) begin
         decValid <= 1'b0;
      end else if (cmdReady) begin
         decValid <= cmdValid;
      end
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         decOp       <= cmdOp;
         decDst      <= cmdDst;
         decSrcA     <= cmdSrcA;
         decSrcB     <= cmdSrcB;
         decImm      <= cmdImm;
         decUseImm   <= cmdUseImm;
         decRegWrite <= (cmdOp != aluPkg::opCmp);
         decUpdOvf   <= cmdOp inside {aluPkg::opAdd, aluPkg::opAdc,
                                      aluPkg::opSub, aluPkg::opCmp};
         // arithmetic plus all shifts touch carry
         decUpdCarry <= cmdOp inside {aluPkg::opAdd, aluPkg::opAdc,
                                      aluPkg::opSub, aluPkg::opCmp,
                                      aluPkg::opLsl, aluPkg::opLsr,
                                      aluPkg::opAsr, aluPkg::opRor};
      end
   end

endmodule

/* design/regFile.sv */
`timescale 1ns/1ps

module regFile (
   input  logic              clk,
   input  logic              rst,
   input  logic              wrEn,
   input  aluPkg::regAddr_t  wrAddr,
   input  aluPkg::data_t     wrData,
   input  aluPkg::regAddr_t  rdAddrA,
   input  aluPkg::regAddr_t  rdAddrB,
   output aluPkg::data_t     rdDataA,
   output aluPkg::data_t     rdDataB
);

   aluPkg::data_t regs [aluPkg::regCount];

   // write port
   always_ff @(posedge clk) begin
      if (rst) begin
         for (int i = 0; i < aluPkg::regCount; i++) begin
            regs[i] <= '0;
         end
      end else if (wrEn) begin
         regs[wrAddr] <= wrData;
      end
   end

   // async reads, a write shows up on the next cycle
   assign rdDataA = regs[rdAddrA];
   assign rdDataB = regs[rdAddrB];

endmodule

/* design/aluCore.sv */
`timescale 1ns/1ps

module aluCore (
   input  aluPkg::aluOp_e  op,
   input  aluPkg::data_t   a,
   input  aluPkg::data_t   b,
   input  logic            carryIn,
   output aluPkg::data_t   result,
   output logic            carryOut,
   output logic            ovfOut
);

   logic                        isSub;
   logic                        addCin;
   aluPkg::data_t               addB;
   logic [aluPkg::dataWidth:0]  sum; // ninth bit is carry out
   logic                        sumOvf;

   // one shared adder, subtract is a + ~b + 1
   always_comb begin
      isSub  = (op == aluPkg::opSub) || (op == aluPkg::opCmp);
      addB   = isSub ? ~b : b;
      if (isSub) begin
         addCin = 1'b1;
      end else if (op == aluPkg::opAdc) begin
         addCin = carryIn;
      end else begin
         addCin = 1'b0;
      end
      sum = {1'b0, a} + {1'b0, addB} + {{aluPkg::dataWidth{1'b0}}, addCin};
      // same sign in, different sign out
      sumOvf = (a[aluPkg::dataWidth-1] == addB[aluPkg::dataWidth-1]) &&
               (sum[aluPkg::dataWidth-1] != a[aluPkg::dataWidth-1]);
   end

   always_comb begin
      result   = a;
      carryOut = carryIn; // ignored unless the op updates C
      ovfOut   = 1'b0;
      case (op)
         aluPkg::opPassA: begin
            result = a;
         end
         aluPkg::opPassB: begin
            result = b;
         end
         aluPkg::opNotA: begin
            result = ~a;
         end
         aluPkg::opNotB: begin
            result = ~b;
         end
         aluPkg::opAdd, aluPkg::opAdc, aluPkg::opSub, aluPkg::opCmp: begin
            result   = sum[aluPkg::dataWidth-1:0];
            carryOut = sum[aluPkg::dataWidth];
            ovfOut   = sumOvf;
         end
         aluPkg::opAnd: begin
            result = a & b;
         end
         aluPkg::opOr: begin
            result = a | b;
         end
         aluPkg::opNand: begin
            result = ~(a & b);
         end
         aluPkg::opXor: begin
            result = a ^ b;
         end
         aluPkg::opLsl: begin
            result   = {a[aluPkg::dataWidth-2:0], 1'b0};
            carryOut = a[aluPkg::dataWidth-1];
         end
         aluPkg::opLsr: begin
            result   = {1'b0, a[aluPkg::dataWidth-1:1]};
            carryOut = a[0];
         end
         aluPkg::opAsr: begin
            result   = {a[aluPkg::dataWidth-1], a[aluPkg::dataWidth-1:1]}; // sign kept
            carryOut = a[0];
         end
         aluPkg::opRor: begin
            result   = {a[0], a[aluPkg::dataWidth-1:1]};
            carryOut = a[0];
         end
         default: begin
            result = a;
         end
      endcase
   end

endmodule

/* design/aluExecute.sv */
`timescale 1ns/1ps

module aluExecute (
   input  logic              clk,
   input  logic              rst,
   input  logic              decValid,
   input  aluPkg::aluOp_e    decOp,
   input  aluPkg::regAddr_t  decDst,
   input  aluPkg::regAddr_t  decSrcA,
   input  aluPkg::regAddr_t  decSrcB,
   input  aluPkg::data_t     decImm,
   input  logic              decUseImm,
   input  logic              decRegWrite,
   input  logic              decUpdCarry,
   input  logic              decUpdOvf,
   input  logic              bufReady,
   output logic              exeReady,
   output logic              exeValid,
   output aluPkg::data_t     exeData,
   output aluPkg::flags_t    exeFlags
);

   aluPkg::data_t   regA;
   aluPkg::data_t   regB;
   aluPkg::data_t   opB;
   aluPkg::data_t   aluResult;
   logic            aluCarry;
   logic            aluOvf;
   aluPkg::flags_t  flags;
   aluPkg::flags_t  nextFlags;
   logic            advance;

   assign advance  = decValid && bufReady;
   assign exeReady = advance;
   assign opB      = decUseImm ? decImm : regB;

   regFile regFile_i (
      .clk     (clk),
      .rst     (rst),
      .wrEn    (advance && decRegWrite),
      .wrAddr  (decDst),
      .wrData  (aluResult),
      .rdAddrA (decSrcA),
      .rdAddrB (decSrcB),
      .rdDataA (regA),
      .rdDataB (regB)
   );

   aluCore aluCore_i (
      .op       (decOp),
      .a        (regA),
      .b        (opB),
      .carryIn  (flags[aluPkg::flagC]), // stored carry for adc
      .result   (aluResult),
      .carryOut (aluCarry),
      .ovfOut   (aluOvf)
   );

   // Z and N always follow the result, C and V only when the op owns them
   always_comb begin
      nextFlags               = flags;
      nextFlags[aluPkg::flagZ] = (aluResult == '0);
      nextFlags[aluPkg::flagN] = aluResult[aluPkg::dataWidth-1];
      if (decUpdCarry) nextFlags[aluPkg::flagC] = aluCarry;
      if (decUpdOvf) nextFlags[aluPkg::flagV] = aluOvf;
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         flags <= '0;
      end else if (advance) begin
         flags <= nextFlags;
      end
   end

   assign exeValid = advance;
   assign exeData  = aluResult;
   assign exeFlags = nextFlags; // flags after this command

endmodule

/* design/resultBuffer.sv */
`timescale 1ns/1ps

module resultBuffer (
   input  logic            clk,
   input  logic            rst,
   input  logic            exeValid,
   input  aluPkg::data_t   exeData,
   input  aluPkg::flags_t  exeFlags,
   input  logic            resReady,
   output logic            bufReady,
   output logic            resValid,
   output aluPkg::data_t   resData,
   output aluPkg::flags_t  resFlags
);

   // free now or leaving this edge
   assign bufReady = !resValid || resReady;

   always_ff @(posedge clk) begin
      if (rst) begin
         resValid <= 1'b0;
      end else if (bufReady) begin
         resValid <= exeValid;
      end
   end

   always_ff @(posedge clk) begin
      if (bufReady && exeValid) begin
         resData  <= exeData;
         resFlags <= exeFlags;
      end
   end

endmodule

/* design/aluDatapath.sv */
`timescale 1ns/1ps

module aluDatapath (
   input  logic              clk,
   input  logic              rst,
   input  logic              cmdValid,
   input  aluPkg::aluOp_e    cmdOp,
   input  aluPkg::regAddr_t  cmdDst,
   input  aluPkg::regAddr_t  cmdSrcA,
   input  aluPkg::regAddr_t  cmdSrcB,
   input  aluPkg::data_t     cmdImm,
   input  logic              cmdUseImm,
   output logic              cmdReady,
   output logic              resValid,
   output aluPkg::data_t     resData,
   output aluPkg::flags_t    resFlags,
   input  logic              resReady
);

   // decode to execute
   logic              decValid;
   aluPkg::aluOp_e    decOp;
   aluPkg::regAddr_t  decDst;
   aluPkg::regAddr_t  decSrcA;
   aluPkg::regAddr_t  decSrcB;
   aluPkg::data_t     decImm;
   logic              decUseImm;
   logic              decRegWrite;
   logic              decUpdCarry;
   logic              decUpdOvf;
   logic              exeReady;

   // execute to output buffer
   logic              exeValid;
   aluPkg::data_t     exeData;
   aluPkg::flags_t    exeFlags;
   logic              bufReady;

   cmdDecode cmdDecode_i (
      .clk(clk), .rst(rst),
      .cmdValid(cmdValid), .cmdOp(cmdOp), .cmdDst(cmdDst),
      .cmdSrcA(cmdSrcA), .cmdSrcB(cmdSrcB), .cmdImm(cmdImm),
      .cmdUseImm(cmdUseImm), .exeReady(exeReady), .cmdReady(cmdReady),
      .decValid(decValid), .decOp(decOp), .decDst(decDst),
      .decSrcA(decSrcA), .decSrcB(decSrcB), .decImm(decImm),
      .decUseImm(decUseImm), .decRegWrite(decRegWrite),
      .decUpdCarry(decUpdCarry), .decUpdOvf(decUpdOvf)
   );

   aluExecute aluExecute_i (
      .clk(clk), .rst(rst),
      .decValid(decValid), .decOp(decOp), .decDst(decDst),
      .decSrcA(decSrcA), .decSrcB(decSrcB), .decImm(decImm),
      .decUseImm(decUseImm), .decRegWrite(decRegWrite),
      .decUpdCarry(decUpdCarry), .decUpdOvf(decUpdOvf),
      .bufReady(bufReady), .exeReady(exeReady),
      .exeValid(exeValid), .exeData(exeData), .exeFlags(exeFlags)
   );

   resultBuffer resultBuffer_i (
      .clk(clk), .rst(rst),
      .exeValid(exeValid), .exeData(exeData), .exeFlags(exeFlags),
      .resReady(resReady), .bufReady(bufReady),
      .resValid(resValid), .resData(resData), .resFlags(resFlags)
   );

endmodule

/* dv/aluDatapath_assert.sv */
`timescale 1ns/1ps

module aluDatapath_assert (
   input logic            clk,
   input logic            rst,
   input logic            cmdReady,
   input logic            resValid,
   input logic            resReady,
   input aluPkg::data_t   resData,
   input aluPkg::flags_t  resFlags
);

   int failCount = 0; // summed into the testbench error count

   holdWhileStalled: assert property (@(posedge clk) disable iff (rst)
      resValid && !resReady |=> $stable(resData) && $stable(resFlags))
      else begin
         $error("result data or flags changed while the output was stalled");
         failCount++;
      end

   // first cycle out of reset
   idleAfterReset: assert property (@(posedge clk) rst |=> !resValid && cmdReady)
      else begin
         $error("output valid or command not ready right after reset");
         failCount++;
      end

   knownResult: assert property (@(posedge clk) disable iff (rst)
      resValid |-> !$isunknown(resData))
      else begin
         $error("result data has unknown bits while valid");
         failCount++;
      end

endmodule

bind aluDatapath aluDatapath_assert aluDatapathAssert_i (.*);

/* dv/aluDatapathTb.sv */
`timescale 1ns/1ps

module aluDatapathTb;

   localparam int clkPeriod  = 100;
   localparam int stallLimit = 400; // cycles without a result before giving up
   localparam int modeRead   = 0;
   localparam int modeWrite  = 1;
   localparam int modeArith  = 2;
   localparam int modeLogic  = 3;
   localparam int modeAll    = 4;
   localparam int totalCmds  = 4 * aluPkg::regCount + 200 + 200 + 150 + 400;
   localparam int msb        = aluPkg::dataWidth - 1;

   logic              clk;
   logic              rst;
   logic              cmdValid;
   aluPkg::aluOp_e    cmdOp;
   aluPkg::regAddr_t  cmdDst;
   aluPkg::regAddr_t  cmdSrcA;
   aluPkg::regAddr_t  cmdSrcB;
   aluPkg::data_t     cmdImm;
   logic              cmdUseImm;
   logic              cmdReady;
   logic              resValid;
   aluPkg::data_t     resData;
   aluPkg::flags_t    resFlags;
   logic              resReady;

   logic [31:0]       lcgState = 32'd45566;
   aluPkg::data_t     modelRegs [aluPkg::regCount];
   aluPkg::flags_t    modelFlags;
   aluPkg::data_t     expData [$];
   aluPkg::flags_t    expFlags [$];
   string             testName;
   int                dataErrors = 0;
   int                flagErrors = 0;
   int                otherErrors = 0;
   int                assertErrors = 0;

   aluDatapath aluDatapath_i (.*);

   initial begin
      clk = 1'b0;
      forever #(clkPeriod / 2) clk = ~clk;
   end

   function automatic logic [31:0] nextRand();
      lcgState = lcgState * 32'd1664525 + 32'd1013904223;
      return lcgState >> 8; // low bits of an lcg are weak
   endfunction

   function automatic aluPkg::aluOp_e pickOp(input int mode);
      aluPkg::aluOp_e arithOps [4];
      aluPkg::aluOp_e logicOps [10];
      arithOps = '{aluPkg::opAdd, aluPkg::opAdc, aluPkg::opSub, aluPkg::opCmp};
      logicOps = '{aluPkg::opAnd, aluPkg::opOr, aluPkg::opNand, aluPkg::opXor,
                   aluPkg::opNotA, aluPkg::opNotB, aluPkg::opLsl, aluPkg::opLsr,
                   aluPkg::opAsr, aluPkg::opRor};
      if (mode == modeArith) begin
         return arithOps[nextRand() % 4];
      end else if (mode == modeLogic) begin
         return logicOps[nextRand() % 10];
      end
      return aluPkg::aluOp_e'(nextRand() % 16);
   endfunction

   task automatic checkData(input string name, input aluPkg::data_t expected,
                            input aluPkg::data_t actual);
      if (actual !== expected) begin
         dataErrors++;
         $display("[ERROR] %s: data expected %h, actual %h", name, expected, actual);
      end
   endtask

   task automatic checkFlags(input string name, input aluPkg::flags_t expected,
                             input aluPkg::flags_t actual);
      if (actual !== expected) begin
         flagErrors++;
         $display("[ERROR] %s: flags expected %b, actual %b", name, expected, actual);
      end
   endtask

   // reference model, applied to the command being accepted
   task automatic applyModel();
      aluPkg::data_t               a;
      aluPkg::data_t               b;
      aluPkg::data_t               nb;
      aluPkg::data_t               r;
      logic [aluPkg::dataWidth:0]  wide;
      a  = modelRegs[cmdSrcA];
      b  = cmdUseImm ? cmdImm : modelRegs[cmdSrcB];
      nb = ~b;
      r  = a;
      case (cmdOp)
         aluPkg::opPassB: r = b;
         aluPkg::opNotA:  r = ~a;
         aluPkg::opNotB:  r = ~b;
         aluPkg::opAnd:   r = a & b;
         aluPkg::opOr:    r = a | b;
         aluPkg::opNand:  r = ~(a & b);
         aluPkg::opXor:   r = a ^ b;
         aluPkg::opAdd, aluPkg::opAdc: begin
            wide = a + b + ((cmdOp == aluPkg::opAdc) ? modelFlags[aluPkg::flagC] : 1'b0);
            r    = wide[msb:0];
            modelFlags[aluPkg::flagC] = wide[aluPkg::dataWidth];
            modelFlags[aluPkg::flagV] = (a[msb] == b[msb]) && (r[msb] != a[msb]);
         end
         aluPkg::opSub, aluPkg::opCmp: begin
            wide = a + nb + 1'b1;
            r    = wide[msb:0];
            modelFlags[aluPkg::flagC] = wide[aluPkg::dataWidth]; // set means no borrow
            modelFlags[aluPkg::flagV] = (a[msb] != b[msb]) && (r[msb] != a[msb]);
         end
         aluPkg::opLsl: begin
            r = a << 1;
            modelFlags[aluPkg::flagC] = a[msb];
         end
         aluPkg::opLsr: begin
            r = a >> 1;
            modelFlags[aluPkg::flagC] = a[0];
         end
         aluPkg::opAsr: begin
            r = {a[msb], a[msb:1]};
            modelFlags[aluPkg::flagC] = a[0];
         end
         aluPkg::opRor: begin
            r = {a[0], a[msb:1]};
            modelFlags[aluPkg::flagC] = a[0];
         end
         default: r = a;
      endcase
      modelFlags[aluPkg::flagZ] = (r == '0);
      modelFlags[aluPkg::flagN] = r[msb];
      if (cmdOp != aluPkg::opCmp) modelRegs[cmdDst] = r;
      expData.push_back(r);
      expFlags.push_back(modelFlags);
   endtask

   task automatic collectResult();
      if (expData.size() == 0) begin
         otherErrors++;
         $display("%s: result %h arrived with no command outstanding", testName, resData);
      end else begin
         checkData(testName, expData.pop_front(), resData);
         checkFlags(testName, expFlags.pop_front(), resFlags);
      end
   endtask

   task automatic loadCmd(input int mode, input int idx);
      cmdDst    = aluPkg::regAddr_t'(nextRand());
      cmdSrcA   = aluPkg::regAddr_t'(nextRand());
      cmdSrcB   = aluPkg::regAddr_t'(nextRand());
      cmdImm    = aluPkg::data_t'(nextRand());
      cmdUseImm = 1'(nextRand());
      cmdOp     = pickOp(mode);
      if (mode == modeRead) begin
         cmdOp   = aluPkg::opPassA;
         cmdSrcA = aluPkg::regAddr_t'(idx);
      end else if (mode == modeWrite) begin
         cmdOp     = aluPkg::opPassB;
         cmdDst    = aluPkg::regAddr_t'(idx);
         cmdUseImm = 1'b1;
      end
   endtask

   // handshakes are decided just after the falling edge, ahead of the next rising edge
   task automatic runPhase(input string name, input int count, input int mode,
                           input int readyPct);
      int   sent;
      int   received;
      int   idle;
      int   holdLeft;
      logic accepted;
      testName = name;
      sent     = 0;
      received = 0;
      idle     = 0;
      holdLeft = 0;
      accepted = 1'b0;
      while (received < count && idle < stallLimit) begin
         @(negedge clk);
         if (accepted) cmdValid = 1'b0;
         if (!cmdValid && sent < count && nextRand() % 4 != 0) begin
            loadCmd(mode, sent % aluPkg::regCount);
            cmdValid = 1'b1;
         end
         if (holdLeft == 0) begin
            resReady = (nextRand() % 100) < readyPct; // held for a random run
            holdLeft = 1 + nextRand() % 12;
         end
         holdLeft--;
         #1;
         idle++;
         accepted = cmdValid && cmdReady;
         if (accepted) begin
            applyModel();
            sent++;
         end
         if (resValid && resReady) begin
            collectResult();
            received++;
            idle = 0;
         end
      end
      if (received < count) begin
         otherErrors++;
         $display("%s: pipeline stalled with %0d results missing", name, count - received);
         expData.delete();
         expFlags.delete();
      end
      @(negedge clk);
      cmdValid = 1'b0;
   endtask

   initial begin
      rst        = 1'b1;
      cmdValid   = 1'b0;
      cmdOp      = aluPkg::opPassA;
      cmdDst     = '0;
      cmdSrcA    = '0;
      cmdSrcB    = '0;
      cmdImm     = '0;
      cmdUseImm  = 1'b0;
      resReady   = 1'b0;
      modelFlags = '0;
      for (int i = 0; i < aluPkg::regCount; i++) begin
         modelRegs[i] = '0;
      end
      repeat (5) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;

      runPhase("reset readback", aluPkg::regCount, modeRead, 100);
      runPhase("immediate write", aluPkg::regCount, modeWrite, 100);
      runPhase("immediate readback", aluPkg::regCount, modeRead, 100);
      runPhase("arithmetic", 200, modeArith, 70);
      runPhase("arithmetic readback", aluPkg::regCount, modeRead, 70); // cmp left dst alone
      runPhase("logic and shift", 200, modeLogic, 70);
      runPhase("back-pressure", 150, modeAll, 25);
      runPhase("random mix", 400, modeAll, 60);

      // anything left in the pipeline now is spurious
      testName = "drain";
      resReady = 1'b1;
      repeat (10) begin
         @(negedge clk);
         #1;
         if (resValid) collectResult();
      end
      if (expData.size() != 0) begin
         otherErrors++;
         $display("%0d expected results never arrived", expData.size());
      end

      assertErrors = aluDatapath_i.aluDatapathAssert_i.failCount;
      $display("errors: data %0d, flags %0d, other %0d, assertions %0d",
               dataErrors, flagErrors, otherErrors, assertErrors);
      if (dataErrors + flagErrors + otherErrors + assertErrors == 0) begin
         $display("Simulation passed");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

   initial begin
      #(totalCmds * 10 * clkPeriod);
      $display("watchdog expired after %0d cycles, the run did not finish", totalCmds * 10);
      $display("Simulation failed");
      $finish;
   end

endmodule

/* sources.f */
design/aluPkg.sv
design/cmdDecode.sv
design/regFile.sv
design/aluCore.sv
design/aluExecute.sv
design/resultBuffer.sv
design/aluDatapath.sv
dv/aluDatapath_assert.sv
dv/aluDatapathTb.sv
